/* verilog/icache_pkg.sv */
package icache_pkg;

    localparam int ADDR_W  = 64;
    localparam int INDEX_W = 6;
    localparam int TAG_W   = 55;
    localparam int WAYS    = 8;
    localparam int WAY_W   = 3;
    localparam int LINE_W  = 64;
    localparam int INST_W  = 32;
    localparam int SETS    = 1 << INDEX_W;

    // cache view of the fetch address
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic               word_sel;
        logic [1:0]         byte_off;
    } fetch_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        fetch_fields_t     fields;
    } fetch_addr_t;

    typedef enum logic [2:0] {
        st_idle,
        st_read_cache,
        st_ar,
        st_r,
        st_fill,
        st_done
    } fetch_state_t;

endpackage

/* verilog/icache_tag_array.sv */
`timescale 1ns/10ps

module icache_tag_array
    import icache_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  fetch_addr_t      pc,
    input  logic             fence_i,
    input  logic             fill_en,
    input  logic [WAY_W-1:0] fill_way,
    output logic             hit,
    output logic [WAY_W-1:0] hit_way,
    output logic             free_found,
    output logic [WAY_W-1:0] free_way
);

    logic [WAYS-1:0]  valid [SETS];
    logic [TAG_W-1:0] tags  [WAYS][SETS];
    logic [WAYS-1:0]  set_valid;
    logic [WAYS-1:0]  way_match;

    assign set_valid = valid[pc.fields.index];

    // all ways of the set compared at once
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_match[w] = set_valid[w] && (tags[w][pc.fields.index] == pc.fields.tag);
        end
    end

    assign hit = |way_match;

    // at most one way matches
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_match[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    // lowest invalid way wins
    always_comb begin
        free_found = ~&set_valid;
        free_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                free_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_en) begin
            valid[pc.fields.index][fill_way] <= 1'b1;
        end else if (fence_i) begin
            // fence.i drops every line
            for (int s = 0; s < SETS; s++) begin
                valid[s] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_way][pc.fields.index] <= pc.fields.tag;
        end
    end

endmodule

/* verilog/icache_plru.sv */
`timescale 1ns/10ps

module icache_plru
    import icache_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  fetch_addr_t      pc,
    input  logic             hit_upd,
    input  logic [WAY_W-1:0] hit_way,
    output logic [WAY_W-1:0] victim_way
);

    localparam int TREE_W = WAYS - 1;

    // bit 0 root, bits 1-2 middle, bits 3-6 leaves
    logic [TREE_W-1:0] tree [SETS];
    logic [TREE_W-1:0] cur_tree;
    logic [TREE_W-1:0] upd_tree;

    assign cur_tree = tree[pc.fields.index];

    // node n has children 2n+1 (lower half) and 2n+2 (upper half)
    always_comb begin
        int node;
        node = 0;
        victim_way = '0;
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            victim_way[WAY_W-1-lvl] = cur_tree[node];
            node = 2 * node + 1 + int'(cur_tree[node]);
        end
    end

    // path bits point away from the way just used
    always_comb begin
        int node;
        node = 0;
        upd_tree = cur_tree;
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            upd_tree[node] = ~hit_way[WAY_W-1-lvl];
            node = 2 * node + 1 + int'(hit_way[WAY_W-1-lvl]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (hit_upd) begin
            tree[pc.fields.index] <= upd_tree;
        end
    end

endmodule

/* verilog/icache_data_array.sv */
`timescale 1ns/10ps

module icache_data_array
    import icache_pkg::*;
(
    input  logic              clk,
    input  fetch_addr_t       pc,
    input  logic              fill_en,
    input  logic [WAY_W-1:0]  fill_way,
    input  logic [LINE_W-1:0] fill_line,
    input  logic [WAY_W-1:0]  hit_way,
    output logic [LINE_W-1:0] hit_line
);

    // one line per way and set
    logic [LINE_W-1:0] lines [WAYS][SETS];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            lines[fill_way][pc.fields.index] <= fill_line;
        end
    end

    // async read of the hitting way
    assign hit_line = lines[hit_way][pc.fields.index];

endmodule

/* verilog/icache_fetch_ctrl.sv */
`timescale 1ns/10ps

module icache_fetch_ctrl
    import icache_pkg::*;
#(
    parameter logic [31:0] CACHE_BASE  = 32'h8000_0000,
    parameter logic [31:0] CACHE_LIMIT = 32'h8800_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  fetch_addr_t       pc,
    output logic              ack,
    output logic [INST_W-1:0] inst,
    input  logic              hit,
    input  logic [WAY_W-1:0]  hit_way,
    input  logic              free_found,
    input  logic [WAY_W-1:0]  free_way,
    input  logic [WAY_W-1:0]  victim_way,
    input  logic [LINE_W-1:0] hit_line,
    output logic              fill_en,
    output logic [WAY_W-1:0]  fill_way,
    output logic [LINE_W-1:0] fill_line,
    output logic              hit_upd,
    output logic              arvalid,
    input  logic              arready,
    output logic [31:0]       araddr,
    output logic [2:0]        arsize,
    input  logic              rvalid,
    output logic              rready,
    input  logic [LINE_W-1:0] rdata,
    input  logic              rlast
);

    fetch_state_t       state;
    fetch_state_t       state_nxt;
    logic               cacheable;
    logic               beat;
    logic [LINE_W-1:0]  line_buf;

    function automatic logic [INST_W-1:0] pick_half(input logic [LINE_W-1:0] line,
                                                    input logic upper);
        return upper ? line[LINE_W-1:INST_W] : line[INST_W-1:0];
    endfunction

    assign cacheable = (pc.raw[31:0] >= CACHE_BASE) && (pc.raw[31:0] < CACHE_LIMIT);
    assign beat = rvalid && rlast;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req) begin
                    if (cacheable && hit) begin
                        state_nxt = st_read_cache;
                    end else begin
                        state_nxt = st_ar;
                    end
                end
            end
            st_read_cache: begin
                state_nxt = st_done;
            end
            st_ar: begin
                if (arready) begin
                    state_nxt = st_r;
                end
            end
            st_r: begin
                if (beat) begin
                    state_nxt = cacheable ? st_fill : st_done;
                end
            end
            st_fill: begin
                state_nxt = st_read_cache;
            end
            st_done: begin
                // wait for req to drop
                if (!req) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign ack = (state == st_done);

    // address and size follow the pc
    assign arvalid = (state == st_ar);
    assign araddr  = cacheable ? {pc.raw[31:3], 3'b000} : pc.raw[31:0];
    assign arsize  = cacheable ? 3'd3 : 3'd2;
    assign rready  = (state == st_r);

    always_ff @(posedge clk) begin
        if (state == st_r && beat) begin
            line_buf <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_read_cache) begin
            inst <= pick_half(hit_line, pc.fields.word_sel);
        end else if (state == st_r && beat && !cacheable) begin
            inst <= pick_half(rdata, pc.fields.word_sel);
        end
    end

    // refill goes to a free way first, else the plru victim
    assign fill_en   = (state == st_fill);
    assign fill_way  = free_found ? free_way : victim_way;
    assign fill_line = line_buf;

    assign hit_upd = (state == st_read_cache);

endmodule

/* verilog/icache_fetch_top.sv */
`timescale 1ns/10ps

module icache_fetch_top
    import icache_pkg::*;
#(
    parameter logic [31:0] CACHE_BASE  = 32'h8000_0000,
    parameter logic [31:0] CACHE_LIMIT = 32'h8800_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  fetch_addr_t       pc,
    input  logic              fence_i,
    output logic              ack,
    output logic [INST_W-1:0] inst,
    output logic              arvalid,
    input  logic              arready,
    output logic [31:0]       araddr,
    output logic [2:0]        arsize,
    input  logic              rvalid,
    output logic              rready,
    input  logic [LINE_W-1:0] rdata,
    input  logic              rlast
);

    logic              hit;
    logic [WAY_W-1:0]  hit_way;
    logic              free_found;
    logic [WAY_W-1:0]  free_way;
    logic [WAY_W-1:0]  victim_way;
    logic [LINE_W-1:0] hit_line;
    logic              fill_en;
    logic [WAY_W-1:0]  fill_way;
    logic [LINE_W-1:0] fill_line;
    logic              hit_upd;

    icache_tag_array u_tag_array (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .fence_i    (fence_i),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .free_found (free_found),
        .free_way   (free_way)
    );

    icache_plru u_plru (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .hit_upd    (hit_upd),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    icache_data_array u_data_array (
        .clk        (clk),
        .pc         (pc),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_line  (fill_line),
        .hit_way    (hit_way),
        .hit_line   (hit_line)
    );

    icache_fetch_ctrl #(
        .CACHE_BASE  (CACHE_BASE),
        .CACHE_LIMIT (CACHE_LIMIT)
    ) u_fetch_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .pc         (pc),
        .ack        (ack),
        .inst       (inst),
        .hit        (hit),
        .hit_way    (hit_way),
        .free_found (free_found),
        .free_way   (free_way),
        .victim_way (victim_way),
        .hit_line   (hit_line),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_line  (fill_line),
        .hit_upd    (hit_upd),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .arsize     (arsize),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rlast      (rlast)
    );

endmodule

/* verification/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              arvalid,
    output logic              arready,
    input  logic [31:0]       araddr,
    input  logic [2:0]        arsize,
    output logic              rvalid,
    input  logic              rready,
    output logic [LINE_W-1:0] rdata,
    output logic              rlast,
    input  logic [LINE_W-1:0] mem_line,
    output logic [31:0]       rd_addr,
    output logic [2:0]        rd_size,
    output int                read_count
);

    integer seed = 32'h7d25;
    logic   busy;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rlast      <= 1'b0;
            rdata      <= '0;
            rd_addr    <= '0;
            rd_size    <= '0;
            read_count <= 0;
            busy       <= 1'b0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                busy       <= 1'b1;
                arready    <= 1'b0;
                rd_addr    <= araddr;
                rd_size    <= arsize;
                read_count <= read_count + 1;
            end else begin
                // ready on about one edge in four
                arready <= (($random(seed) & 3) == 0);
            end
        end else if (rvalid && rready) begin
            busy   <= 1'b0;
            rvalid <= 1'b0;
            rlast  <= 1'b0;
        end else if (!rvalid && (($random(seed) & 3) != 0)) begin
            // single beat, so it is always the last one
            rvalid <= 1'b1;
            rlast  <= 1'b1;
            rdata  <= mem_line;
        end
    end

endmodule

/* verification/icache_fetch_tb.sv */
`timescale 1ns/10ps

module icache_fetch_tb import icache_pkg::*; ();

    localparam logic [31:0] CACHE_BASE  = 32'h8000_0000;
    localparam logic [31:0] CACHE_LIMIT = 32'h8800_0000;
    localparam int          ACK_TIMEOUT = 1000;

    logic              clk;
    logic              rst;
    logic              req;
    fetch_addr_t       pc;
    logic              fence_i;
    logic              ack;
    logic [INST_W-1:0] inst;
    logic              arvalid;
    logic              arready;
    logic [31:0]       araddr;
    logic [2:0]        arsize;
    logic              rvalid;
    logic              rready;
    logic [LINE_W-1:0] rdata;
    logic              rlast;
    logic [LINE_W-1:0] mem_line;
    logic [31:0]       rd_addr;
    logic [2:0]        rd_size;
    int                read_count;
    int                errors = 0;
    int                checks = 0;
    logic              ar_waiting = 1'b0;
    logic [31:0]       ar_held;

    // reference cache state
    logic [WAYS-1:0]  ref_valid [SETS];
    logic [TAG_W-1:0] ref_tag   [SETS][WAYS];
    logic [WAYS-2:0]  ref_tree  [SETS];

    icache_fetch_top #(
        .CACHE_BASE  (CACHE_BASE),
        .CACHE_LIMIT (CACHE_LIMIT)
    ) DUT (
        .clk(clk), .rst(rst), .req(req), .pc(pc), .fence_i(fence_i), .ack(ack), .inst(inst),
        .arvalid(arvalid), .arready(arready), .araddr(araddr), .arsize(arsize),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rlast(rlast)
    );

    axi_mem_model u_mem (
        .clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .arsize(arsize), .rvalid(rvalid), .rready(rready), .rdata(rdata), .rlast(rlast),
        .mem_line(mem_line), .rd_addr(rd_addr), .rd_size(rd_size), .read_count(read_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] expect_inst(input logic [31:0] addr);
        return mem_word({addr[31:2], 2'b00});
    endfunction

    // root 0, middle 1 and 2, leaves 3 to 6
    function automatic logic [2:0] plru_victim(input logic [6:0] t);
        logic [2:0] v;
        v[2] = t[0];
        v[1] = v[2] ? t[2] : t[1];
        v[0] = t[3 + {v[2], v[1]}];
        return v;
    endfunction

    function automatic logic [6:0] plru_update(input logic [6:0] t, input logic [2:0] w);
        logic [6:0] n;
        n = t;
        n[0] = ~w[2];
        n[1 + w[2]] = ~w[1];
        n[3 + w[2:1]] = ~w[0];
        return n;
    endfunction

    assign mem_line = {mem_word({rd_addr[31:3], 3'b100}), mem_word({rd_addr[31:3], 3'b000})};

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        fetch_state_t st;
        st = fetch_state_t'(DUT.u_fetch_ctrl.state);
        $display("timeout while waiting for %s, DUT state %s", what, st.name());
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("TEST FAILED");
        $finish;
    endtask

    // address must hold while arvalid waits
    always @(negedge clk) begin
        if (ar_waiting) begin
            compare_value("araddr hold", {1'b1, ar_held}, {arvalid, araddr});
        end
        ar_waiting = arvalid && !arready;
        ar_held = araddr;
    end

    task automatic run_fetch(input string name, input logic [31:0] addr);
        fetch_addr_t        a;
        logic [INDEX_W-1:0] idx;
        logic               cached;
        logic               hit;
        int                 way;
        int                 reads_before;
        int                 cycles;
        a.raw = {32'h0, addr};
        idx = a.fields.index;
        cached = (addr >= CACHE_BASE) && (addr < CACHE_LIMIT);
        hit = 1'b0;
        way = -1;
        if (cached) begin
            for (int w = 0; w < WAYS; w++) begin
                if (ref_valid[idx][w] && ref_tag[idx][w] == a.fields.tag) begin
                    hit = 1'b1;
                    way = w;
                end
            end
            if (!hit) begin
                for (int w = WAYS - 1; w >= 0; w--) begin
                    if (!ref_valid[idx][w]) begin
                        way = w;
                    end
                end
                if (way < 0) begin
                    way = plru_victim(ref_tree[idx]);
                end
                ref_valid[idx][way] = 1'b1;
                ref_tag[idx][way] = a.fields.tag;
            end
            ref_tree[idx] = plru_update(ref_tree[idx], WAY_W'(way));
        end
        reads_before = read_count;
        @(posedge clk);
        req <= 1'b1;
        pc <= a;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack && cycles < ACK_TIMEOUT);
        if (!ack) begin
            abort_on_timeout({name, " ack"});
        end
        compare_value({name, " inst"}, expect_inst(addr), inst);
        compare_value({name, " reads"}, hit ? 0 : 1, read_count - reads_before);
        if (hit) begin
            // first negedge comes before the sampling edge
            compare_value({name, " latency"}, 2, cycles - 1);
        end else begin
            compare_value({name, " araddr"}, cached ? {addr[31:3], 3'b000} : addr, rd_addr);
            compare_value({name, " arsize"}, cached ? 3 : 2, rd_size);
        end
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack && cycles < ACK_TIMEOUT);
        if (ack) begin
            abort_on_timeout({name, " ack to fall"});
        end
    endtask

    initial begin
        rst = 1'b1;
        req = 1'b0;
        pc = '0;
        fence_i = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            ref_valid[s] = '0;
            ref_tree[s] = '0;
        end
        repeat (16) begin
            @(negedge clk);
            compare_value("reset outputs", 0, {ack, arvalid, rready});
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value("outputs after reset", 0, {ack, arvalid, rready});

        run_fetch("first cached", 32'h8000_0100);
        run_fetch("uncached", 32'h1000_0204);
        run_fetch("uncached repeat", 32'h1000_0204);
        run_fetch("same line hit", 32'h8000_0104);

        // nine tags into set 5
        for (int k = 0; k < 9; k++) begin
            run_fetch("fill set", 32'h8000_0028 + k * 32'h200);
        end
        for (int k = 0; k < 8; k++) begin
            run_fetch("refetch set", 32'h8000_002c + k * 32'h200);
        end

        @(posedge clk);
        fence_i <= 1'b1;
        @(posedge clk);
        fence_i <= 1'b0;
        for (int s = 0; s < SETS; s++) begin
            ref_valid[s] = '0;
        end
        run_fetch("after fence", 32'h8000_0104);

        for (int i = 0; i < 40; i++) begin
            if (i % 6 == 5) begin
                run_fetch("random delay", 32'h2000_0000 + i * 8);
            end else begin
                run_fetch("random delay",
                          32'h8000_0000 + ((i * 7) % 5) * 32'h200 + ((i * 3) % 8) * 4);
            end
        end

        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* icache_fetch_top.f */
verilog/icache_pkg.sv
verilog/icache_tag_array.sv
verilog/icache_plru.sv
verilog/icache_data_array.sv
verilog/icache_fetch_ctrl.sv
verilog/icache_fetch_top.sv
verification/axi_mem_model.sv
verification/icache_fetch_tb.sv
